//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --assert --top-module tb_arb_wrr -f sim.f -o tb_arb_wrr \
    > build.log 2>&1 \
    && ./obj_dir/tb_arb_wrr > sim.log 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log

grep -q "TEST FAILED" sim.log \
    && { echo "Simulation reported a failure"; exit 1; } \
    || { echo "Simulation finished without a reported failure"; exit 0; }

//--- sim.f
src/arb_pkg.sv
src/arb_mask_if.sv
src/arb_weight_table.sv
src/arb_credit_stage.sv
src/arb_rr_pick.sv
src/arb_wrr_top.sv
testbench/arb_wrr_properties.sv
testbench/tb_arb_wrr.sv

//--- src/arb_credit_stage.sv
`timescale 1ns/1ps

module arb_credit_stage (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_block_arb,
    input  arb_pkg::client_vec_t  i_req,
    input  arb_pkg::thresh_arr_t  i_thresh,
    arb_mask_if.credit            mask
);
    import arb_pkg::*;

    // Grants taken by each client in the current round
    thresh_arr_t r_crd_cnt;
    thresh_arr_t w_crd_next;

    // Counter plus one, one bit wider so a full counter never wraps back
    // into range during the compare
    logic [THRESH_W:0] w_cnt_inc [CLIENTS];

    client_vec_t w_req_post;
    client_vec_t w_has_crd;
    logic        w_replenish;

    // Blocking removes every request before any credit decision
    // The pick stage therefore never has to look at the block input
    assign w_req_post = i_block_arb ? '0 : i_req;

    // A client has credit while one more grant keeps it within its weight
    always_comb begin
        for (int i = 0; i < CLIENTS; i++) begin
            w_cnt_inc[i] = {1'b0, r_crd_cnt[i]} + 1'b1;
            w_has_crd[i] = (w_cnt_inc[i] <= {1'b0, i_thresh[i]});
        end
    end

    // When no live request has credit the round is over
    // All live requests then compete again as if counters were clear
    assign w_replenish = ((w_req_post & w_has_crd) == '0);

    assign mask.replenish = w_replenish;
    assign mask.req_mask  = w_req_post & (w_has_crd | {CLIENTS{w_replenish}});

    // Counter update for the pick made on this edge
    always_comb begin
        w_crd_next = r_crd_cnt;
        if (mask.pick_stb) begin
            if (w_replenish) begin
                // New round, the picked client has already used one grant
                w_crd_next                = '0;
                w_crd_next[mask.pick_id]  = thresh_t'(1);
            end else begin
                // The picked client had credit, so this cannot pass its weight
                w_crd_next[mask.pick_id] = w_cnt_inc[mask.pick_id][THRESH_W-1:0];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_crd_cnt <= '0;
        end else begin
            r_crd_cnt <= w_crd_next;
        end
    end

endmodule

//--- src/arb_mask_if.sv
`timescale 1ns/1ps

interface arb_mask_if;
    import arb_pkg::*;

    // Requests that survived blocking and the credit check
    client_vec_t req_mask;

    // High when no requesting client has credit left in this round
    logic replenish;

    // One-cycle pulse from the pick stage on the edge where it registers a grant
    logic pick_stb;

    // Index of the client picked on that edge
    client_id_t pick_id;

    // Credit stage side
    modport credit (
        output req_mask,
        output replenish,
        input  pick_stb,
        input  pick_id
    );

    // Pick stage side
    modport picker (
        input  req_mask,
        input  replenish,
        output pick_stb,
        output pick_id
    );

endinterface

//--- src/arb_pkg.sv
package arb_pkg;

    // Number of requesting clients, fixed for this arbiter
    localparam int CLIENTS = 4;

    // Width of a client index
    localparam int ID_W = 2;

    // Width of one threshold and of one credit counter
    localparam int THRESH_W = 4;

    // Weight loaded into every client after reset
    // With a weight of one the arbiter reduces to plain round robin
    localparam int DEFAULT_THRESH = 1;

    // One bit per client, used for requests, masks, grants and acknowledges
    typedef logic [CLIENTS-1:0] client_vec_t;

    // Index of a single client
    typedef logic [ID_W-1:0] client_id_t;

    // A single threshold or credit count
    typedef logic [THRESH_W-1:0] thresh_t;

    // All client thresholds packed together, entry i belongs to client i
    typedef thresh_t [CLIENTS-1:0] thresh_arr_t;

    // Pick stage FSM
    // PICK_IDLE has no grant outstanding, PICK_HELD waits for the acknowledge
    typedef enum logic {
        PICK_IDLE = 1'b0,
        PICK_HELD = 1'b1
    } pick_state_t;

endpackage

//--- src/arb_rr_pick.sv
`timescale 1ns/1ps

module arb_rr_pick (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  arb_pkg::client_vec_t i_gnt_ack,
    arb_mask_if.picker           mask,
    output arb_pkg::client_vec_t o_gnt,
    output arb_pkg::client_id_t  o_gnt_id,
    output logic                 o_gnt_valid
);
    import arb_pkg::*;

    pick_state_t r_state;
    pick_state_t w_state_next;

    // Search start, one past the last client that was picked
    client_id_t  r_ptr;

    client_vec_t r_gnt;
    client_id_t  r_gnt_id;

    client_id_t  w_pick_id;
    logic        w_pick_found;
    logic        w_pick;
    logic        w_ack_hit;

    // First masked request at or above the pointer, wrapping past the top
    always_comb begin
        int idx;
        w_pick_id    = r_ptr;
        w_pick_found = 1'b0;
        for (int off = 0; off < CLIENTS; off++) begin
            idx = (int'(r_ptr) + off) % CLIENTS;
            if (!w_pick_found && mask.req_mask[idx]) begin
                w_pick_found = 1'b1;
                w_pick_id    = client_id_t'(idx);
            end
        end
    end

    // A new pick is only taken with no grant outstanding
    // Replenish is already folded into the mask by the credit stage
    assign w_pick = (r_state == PICK_IDLE) && w_pick_found;

    // Acknowledges on any other client bit are ignored
    assign w_ack_hit = |(i_gnt_ack & r_gnt);

    // The credit stage charges the pick on the same edge that registers it
    assign mask.pick_stb = w_pick;
    assign mask.pick_id  = w_pick_id;

    always_comb begin
        w_state_next = r_state;
        case (r_state)
            PICK_IDLE: if (w_pick) w_state_next = PICK_HELD;
            PICK_HELD: if (w_ack_hit) w_state_next = PICK_IDLE;
            default:   w_state_next = PICK_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state  <= PICK_IDLE;
            r_ptr    <= '0;
            r_gnt    <= '0;
            r_gnt_id <= '0;
        end else begin
            r_state <= w_state_next;
            if (w_pick) begin
                r_gnt    <= client_vec_t'(1) << w_pick_id;
                r_gnt_id <= w_pick_id;
                r_ptr    <= client_id_t'((int'(w_pick_id) + 1) % CLIENTS);
            end else if ((r_state == PICK_HELD) && w_ack_hit) begin
                // Release clears the grant for the idle cycle that follows
                r_gnt    <= '0;
                r_gnt_id <= '0;
            end
        end
    end

    assign o_gnt       = r_gnt;
    assign o_gnt_id    = r_gnt_id;
    assign o_gnt_valid = (r_state == PICK_HELD);

endmodule

//--- src/arb_weight_table.sv
`timescale 1ns/1ps

module arb_weight_table (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_cfg_wr,
    input  arb_pkg::client_id_t i_cfg_id,
    input  arb_pkg::thresh_t    i_cfg_thresh,
    output arb_pkg::thresh_arr_t o_thresh
);
    import arb_pkg::*;

    // Each entry is the number of grants a client may take per round
    // A zero entry leaves the client without credit, so it is only
    // served when the credit stage replenishes
    //
    // The table feeds the credit stage directly, a write at one edge is
    // seen by the credit check in the very next cycle and so shapes the
    // next pick

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            // Every client starts with the default weight
            for (int i = 0; i < CLIENTS; i++) begin
                o_thresh[i] <= thresh_t'(DEFAULT_THRESH);
            end
        end else if (i_cfg_wr) begin
            // Only the addressed entry changes, the rest keep their value
            o_thresh[i_cfg_id] <= i_cfg_thresh;
        end
    end

endmodule

//--- src/arb_wrr_top.sv
`timescale 1ns/1ps

module arb_wrr_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_cfg_wr,
    input  arb_pkg::client_id_t  i_cfg_id,
    input  arb_pkg::thresh_t     i_cfg_thresh,
    input  logic                 i_block_arb,
    input  arb_pkg::client_vec_t i_req,
    input  arb_pkg::client_vec_t i_gnt_ack,
    output logic                 o_gnt_valid,
    output arb_pkg::client_vec_t o_gnt,
    output arb_pkg::client_id_t  o_gnt_id
);
    import arb_pkg::*;

    // Current weights from the table into the credit check
    thresh_arr_t w_thresh;

    // Masked requests forward, pick report backward
    arb_mask_if u_mask_if ();

    // Software loads per-client weights here
    arb_weight_table u_weight_table (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_id     (i_cfg_id),
        .i_cfg_thresh (i_cfg_thresh),
        .o_thresh     (w_thresh)
    );

    // Credit counting, blocking and replenish decision
    arb_credit_stage u_credit_stage (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_block_arb (i_block_arb),
        .i_req       (i_req),
        .i_thresh    (w_thresh),
        .mask        (u_mask_if.credit)
    );

    // Round-robin choice and the held grant
    arb_rr_pick u_rr_pick (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_gnt_ack   (i_gnt_ack),
        .mask        (u_mask_if.picker),
        .o_gnt       (o_gnt),
        .o_gnt_id    (o_gnt_id),
        .o_gnt_valid (o_gnt_valid)
    );

endmodule

//--- testbench/arb_cases.txt
# name  thr0 thr1 thr2 thr3  req(hex)  block  count  expected grant ids in order
# Credit counters and the round-robin pointer carry over from one line to the next
#
# Default weights, all clients, plain round robin with a replenish before the last grant
reset_rr     1 1 1 1  f  0  5  0 1 2 3 0
#
# Weights 3 1 2 1, a full round and the replenish at its boundary
weighted     3 1 2 1  f  0  8  1 2 3 0 2 0 1 2
#
# Clients 0 1 3, client 1 has weight zero and only wins replenish picks
subset_zero  2 0 1 1  b  0  8  3 0 0 1 3 0 0 1
#
# Two clients at weight one, the replenish lands on client 1
pair_rr      1 1 1 1  6  0  3  2 1 2
#
# Blocked for 20 cycles with all clients requesting, then released
blocked      1 1 1 1  f  1  4  3 0 1 2
#
# Weights rewritten between cases while the counters keep their state
reconfig_a   2 2 1 1  f  0  5  3 0 1 0 1
reconfig_b   1 1 4 1  f  0  7  2 3 0 2 2 2 3

//--- testbench/arb_wrr_properties.sv
`timescale 1ns/1ps

module arb_wrr_properties (
    input logic                 i_clk,
    input logic                 i_rst_n,
    input arb_pkg::client_vec_t i_gnt_ack,
    input arb_pkg::client_vec_t i_gnt,
    input arb_pkg::client_id_t  i_gnt_id,
    input logic                 i_gnt_valid
);
    import arb_pkg::*;

    // The held grant sees its own acknowledge bit
    logic w_ack_hit;
    assign w_ack_hit = |(i_gnt_ack & i_gnt);

    a_gnt_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(i_gnt))
        else $error("o_gnt has more than one bit set");

    a_valid_or: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_gnt_valid == (|i_gnt))
        else $error("o_gnt_valid does not match the OR of o_gnt");

    a_id_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_gnt_valid |-> (i_gnt == (client_vec_t'(1) << i_gnt_id)))
        else $error("o_gnt_id does not point at the set bit of o_gnt");

    // Without its acknowledge a grant must not move
    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_gnt_valid && !w_ack_hit) |=> (i_gnt_valid && $stable(i_gnt) && $stable(i_gnt_id)))
        else $error("A held grant changed without its acknowledge");

    // The pick stage passes through idle for one cycle after a release
    a_gap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_gnt_valid && w_ack_hit) |=> !i_gnt_valid)
        else $error("A grant followed a release without an idle cycle");

endmodule

bind arb_wrr_top arb_wrr_properties u_props (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_gnt_ack   (i_gnt_ack),
    .i_gnt       (o_gnt),
    .i_gnt_id    (o_gnt_id),
    .i_gnt_valid (o_gnt_valid)
);

//--- testbench/tb_arb_wrr.sv
`timescale 1ns/1ps

module tb_arb_wrr;
    import arb_pkg::*;

    localparam int MAX_GNT      = 16;
    localparam int MAX_CASES    = 64;
    localparam int NAME_W       = 8 * 24;
    localparam int GNT_TIMEOUT  = 50;
    localparam int HOLD_CYCLES  = 10;
    localparam int BLOCK_CYCLES = 20;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_cfg_wr;
    client_id_t  i_cfg_id;
    thresh_t     i_cfg_thresh;
    logic        i_block_arb;
    client_vec_t i_req;
    client_vec_t i_gnt_ack;
    logic        o_gnt_valid;
    client_vec_t o_gnt;
    client_id_t  o_gnt_id;

    // Run totals
    int   err_cnt;
    int   check_cnt;
    int   case_cnt;
    int   case_pass;
    int   case_err;
    logic run_abort;

    // Fields of the case line being run
    logic [NAME_W-1:0] case_name;
    int                thr [CLIENTS];
    int                req_hex;
    int                blk;
    int                gnt_cnt;
    int                exp_id [MAX_GNT];

    arb_wrr_top dut (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cfg_wr     (i_cfg_wr),
        .i_cfg_id     (i_cfg_id),
        .i_cfg_thresh (i_cfg_thresh),
        .i_block_arb  (i_block_arb),
        .i_req        (i_req),
        .i_gnt_ack    (i_gnt_ack),
        .o_gnt_valid  (o_gnt_valid),
        .o_gnt        (o_gnt),
        .o_gnt_id     (o_gnt_id)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // Inputs change and outputs are sampled 2 ns past each rising edge
    task automatic next_cycle();
        @(posedge i_clk);
        #2;
    endtask

    task automatic compare_value(input string sig, input int exp_val, input int act_val);
        check_cnt++;
        if (exp_val != act_val) begin
            $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, sig, exp_val, act_val);
            err_cnt++;
            case_err++;
        end
    endtask

    // The granted index and a one-hot vector on exactly that bit
    task automatic check_grant(input int id);
        compare_value("o_gnt_valid", 1, int'(o_gnt_valid));
        compare_value("o_gnt_id", id, int'(o_gnt_id));
        compare_value("o_gnt", 1 << id, int'(o_gnt));
    endtask

    task automatic write_thresholds();
        for (int i = 0; i < CLIENTS; i++) begin
            i_cfg_wr     = 1'b1;
            i_cfg_id     = client_id_t'(i);
            i_cfg_thresh = thresh_t'(thr[i]);
            next_cycle();
        end
        i_cfg_wr = 1'b0;
    endtask

    task automatic wait_grant(output logic found);
        int n;
        n = 0;
        while (!o_gnt_valid && n < GNT_TIMEOUT) begin
            next_cycle();
            n++;
        end
        found = o_gnt_valid;
    endtask

    // Withhold the acknowledge, then pulse it on every other client bit
    task automatic hold_grant(input int id);
        for (int n = 0; n < HOLD_CYCLES; n++) begin
            next_cycle();
            check_grant(id);
        end
        i_gnt_ack = ~o_gnt;
        next_cycle();
        i_gnt_ack = '0;
        check_grant(id);
    endtask

    // Random acknowledge delay, then a one-cycle pulse on the granted bit
    task automatic release_grant(input int id, input logic last);
        int delay;
        delay = int'($urandom % 32'd4);
        for (int n = 0; n < delay; n++) begin
            next_cycle();
            check_grant(id);
        end
        i_gnt_ack = o_gnt;
        // The final acknowledge of a case drops the requests so no extra pick follows
        if (last) begin
            i_req = '0;
        end
        next_cycle();
        i_gnt_ack = '0;
        compare_value("o_gnt_valid", 0, int'(o_gnt_valid));
    endtask

    task automatic check_blocked();
        for (int n = 0; n < BLOCK_CYCLES; n++) begin
            next_cycle();
            compare_value("o_gnt_valid", 0, int'(o_gnt_valid));
            compare_value("o_gnt", 0, int'(o_gnt));
        end
    endtask

    task automatic skip_line(input int fd);
        int ch;
        for (int n = 0; n < 512; n++) begin
            ch = $fgetc(fd);
            if (ch == 10 || ch == -1) begin
                break;
            end
        end
    endtask

    task automatic read_case(input int fd, output logic got);
        int   r;
        int   n;
        logic done;
        got  = 1'b0;
        done = 1'b0;
        n    = 0;
        while (!done && n < 256) begin
            n++;
            r = $fscanf(fd, "%s", case_name);
            if (r != 1) begin
                done = 1'b1;
            // A lone hash token, right-justified in the name, starts a comment line
            end else if ((case_name[NAME_W-1:8] == '0) && (case_name[7:0] == 8'h23)) begin
                skip_line(fd);
            end else begin
                r = $fscanf(fd, "%d %d %d %d %h %d %d", thr[0], thr[1], thr[2], thr[3],
                            req_hex, blk, gnt_cnt);
                if (r != 7 || gnt_cnt < 0 || gnt_cnt > MAX_GNT) begin
                    $display("Case line %0s in the case file could not be read", case_name);
                    run_abort = 1'b1;
                end else begin
                    got = 1'b1;
                    for (int i = 0; i < gnt_cnt; i++) begin
                        r = $fscanf(fd, "%d", exp_id[i]);
                        if (r != 1) begin
                            got = 1'b0;
                        end
                    end
                    if (!got) begin
                        $display("Case %0s lists fewer grant ids than its count", case_name);
                        run_abort = 1'b1;
                    end
                end
                done = 1'b1;
            end
        end
    endtask

    task automatic run_case();
        logic found;
        case_err = 0;
        case_cnt++;
        i_req       = '0;
        i_block_arb = 1'b0;
        write_thresholds();
        i_req       = client_vec_t'(req_hex);
        i_block_arb = (blk != 0);
        if (blk != 0) begin
            check_blocked();
            i_block_arb = 1'b0;
        end
        for (int g = 0; g < gnt_cnt && !run_abort; g++) begin
            wait_grant(found);
            if (!found) begin
                $display("No grant appeared within %0d cycles in case %0s at grant %0d",
                         GNT_TIMEOUT, case_name, g);
                run_abort = 1'b1;
                case_err++;
            end else begin
                check_grant(exp_id[g]);
                if (g == 0) begin
                    hold_grant(exp_id[g]);
                end
                release_grant(exp_id[g], g == gnt_cnt - 1);
            end
        end
        i_req = '0;
        if (case_err == 0) begin
            case_pass++;
        end
        $display("Case %0s: %0s, %0d grants, %0d errors", case_name,
                 (case_err == 0) ? "passed" : "failed", gnt_cnt, case_err);
    endtask

    initial begin
        int   fd;
        logic got;
        err_cnt   = 0;
        check_cnt = 0;
        case_cnt  = 0;
        case_pass = 0;
        case_err  = 0;
        run_abort = 1'b0;
        void'($urandom(32'h78ab_1e48));
        i_rst_n      = 1'b0;
        i_cfg_wr     = 1'b0;
        i_cfg_id     = '0;
        i_cfg_thresh = '0;
        i_block_arb  = 1'b0;
        i_req        = '0;
        i_gnt_ack    = '0;
        repeat (10) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        next_cycle();

        // Outputs straight out of reset
        compare_value("o_gnt_valid", 0, int'(o_gnt_valid));
        compare_value("o_gnt", 0, int'(o_gnt));
        compare_value("o_gnt_id", 0, int'(o_gnt_id));

        fd = $fopen("testbench/arb_cases.txt", "r");
        if (fd == 0) begin
            $display("The case file testbench/arb_cases.txt could not be opened");
            run_abort = 1'b1;
        end
        got = !run_abort;
        while (got && !run_abort && case_cnt < MAX_CASES) begin
            read_case(fd, got);
            if (got) begin
                run_case();
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Cases %0d, passed %0d, failed %0d, checks %0d, mismatches %0d",
                 case_cnt, case_pass, case_cnt - case_pass, check_cnt, err_cnt);
        if (err_cnt == 0 && !run_abort && case_cnt > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
